// File: source/cell_map_pkg.sv
package cell_map_pkg;

	localparam int NAME_WORDS = 4;
	localparam int MAX_A = 4;
	localparam int A_SLOTS = 8;

	localparam int BUCKET_BITS = 6;
	localparam int SLOT_BITS = 2;
	localparam int OFFSET_BITS = 5;

	localparam int WORD_IDX_W = $clog2(NAME_WORDS);
	localparam int ADDR_IDX_W = $clog2(MAX_A);

	typedef logic [OFFSET_BITS-1:0] offset_t;
	typedef logic [BUCKET_BITS-1:0] bucket_t;

	// Word offsets inside one cell
	localparam offset_t OFS_NAME = 5'd0;
	localparam offset_t OFS_IN_USE = 5'd4;
	localparam offset_t OFS_QUERY_COUNT = 5'd5;
	localparam offset_t OFS_A_COUNT = 5'd6;
	localparam offset_t OFS_A_LIST = 5'd8;

	// Last word of the name and of the address list
	localparam offset_t OFS_NAME_END = OFS_NAME + offset_t'(NAME_WORDS - 1);
	localparam offset_t OFS_A_LIST_END = OFS_A_LIST + offset_t'(A_SLOTS - 1);

	typedef logic [31:0] word_t;
	typedef word_t [NAME_WORDS-1:0] name_t;
	typedef word_t [MAX_A-1:0] addr_list_t;
	typedef logic [2:0] a_count_t;

endpackage

// File: source/store_ctl_pkg.sv
package store_ctl_pkg;

	localparam int WB_ADDR_W = cell_map_pkg::BUCKET_BITS + cell_map_pkg::SLOT_BITS
		+ cell_map_pkg::OFFSET_BITS;

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;

	// Shift amounts of the name hash
	localparam int HASH_SHIFT_LO = 6;
	localparam int HASH_SHIFT_HI = 16;

	typedef enum logic [2:0] {
		CUR_HOLD,
		CUR_LOAD_OFS,
		CUR_STEP_OFS,
		CUR_NEXT_SLOT,
		CUR_NEXT_ADDR,
		CUR_RESET_SLOT
	} cursor_cmd_t;

endpackage

// File: source/name_hash.sv
`timescale 1ns/1ps

module name_hash (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  cell_map_pkg::name_t   name_i,
	output logic                  done_o,
	output cell_map_pkg::bucket_t bucket_o
);

	logic busy;
	logic [cell_map_pkg::WORD_IDX_W-1:0] idx;
	cell_map_pkg::word_t acc;

	function automatic cell_map_pkg::word_t fold(cell_map_pkg::word_t h,
		cell_map_pkg::word_t w);
		return w + (h << store_ctl_pkg::HASH_SHIFT_LO)
			+ (h << store_ctl_pkg::HASH_SHIFT_HI) - h;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				busy <= 1'b1;
				idx <= 1;
			end else if (busy) begin
				idx <= idx + 1'b1;
				if (idx == cell_map_pkg::NAME_WORDS - 1) begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	// Word 0 goes in with the start pulse
	always_ff @(posedge clk) begin
		if (start_i)
			acc <= fold('0, name_i[0]);
		else if (busy)
			acc <= fold(acc, name_i[idx]);
	end

	assign bucket_o = acc[cell_map_pkg::BUCKET_BITS-1:0];

endmodule

// File: source/record_latch.sv
`timescale 1ns/1ps

module record_latch (
	input  logic                                   clk,
	input  logic                                   latch_en_i,
	input  cell_map_pkg::name_t                    qry_name_i,
	input  cell_map_pkg::addr_list_t               ans_addr_i,
	input  cell_map_pkg::a_count_t                 ans_a_count_i,
	input  logic [cell_map_pkg::WORD_IDX_W-1:0]    word_idx_i,
	input  logic [cell_map_pkg::ADDR_IDX_W-1:0]    addr_idx_i,
	output cell_map_pkg::name_t                    name_o,
	output cell_map_pkg::word_t                    name_word_o,
	output cell_map_pkg::word_t                    addr_word_o,
	output cell_map_pkg::a_count_t                 a_count_o
);

	cell_map_pkg::name_t name_q;
	cell_map_pkg::addr_list_t addr_q;
	cell_map_pkg::a_count_t a_count_q;

	always_ff @(posedge clk) begin
		if (latch_en_i) begin
			name_q <= qry_name_i;
			addr_q <= ans_addr_i;
			a_count_q <= ans_a_count_i;
		end
	end

	assign name_o = name_q;
	assign a_count_o = a_count_q;

	// Word for the current name offset and packet address
	assign name_word_o = name_q[word_idx_i];
	assign addr_word_o = addr_q[addr_idx_i];

endmodule

// File: source/cell_cursor.sv
`timescale 1ns/1ps

module cell_cursor (
	input  logic                                clk,
	input  logic                                rst,
	input  store_ctl_pkg::cursor_cmd_t          cmd_i,
	input  cell_map_pkg::offset_t               load_ofs_i,
	input  cell_map_pkg::bucket_t               bucket_i,
	input  cell_map_pkg::a_count_t              a_count_i,
	output store_ctl_pkg::wb_addr_t             wb_addr_o,
	output logic [cell_map_pkg::WORD_IDX_W-1:0] word_idx_o,
	output logic [cell_map_pkg::ADDR_IDX_W-1:0] addr_idx_o,
	output logic                                last_slot_o,
	output logic                                last_addr_o,
	output logic                                list_end_o
);

	logic [cell_map_pkg::SLOT_BITS-1:0] slot;
	cell_map_pkg::offset_t ofs;
	logic [cell_map_pkg::ADDR_IDX_W-1:0] addr_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			ofs <= '0;
			addr_idx <= '0;
		end else begin
			case (cmd_i)
				store_ctl_pkg::CUR_LOAD_OFS: ofs <= load_ofs_i;
				store_ctl_pkg::CUR_STEP_OFS: ofs <= ofs + 1'b1;
				store_ctl_pkg::CUR_NEXT_SLOT: begin
					slot <= slot + 1'b1;
					ofs <= load_ofs_i;
				end
				store_ctl_pkg::CUR_NEXT_ADDR: begin
					addr_idx <= addr_idx + 1'b1;
					ofs <= load_ofs_i;
				end
				store_ctl_pkg::CUR_RESET_SLOT: begin
					slot <= '0;
					addr_idx <= '0;
					ofs <= load_ofs_i;
				end
				default: ;
			endcase
		end
	end

	assign wb_addr_o = {bucket_i, slot, ofs};
	assign word_idx_o = ofs[cell_map_pkg::WORD_IDX_W-1:0];
	assign addr_idx_o = addr_idx;

	assign last_slot_o = &slot;
	assign last_addr_o = cell_map_pkg::a_count_t'(addr_idx) == a_count_i - 1'b1;
	// One end flag serves both walks since they never overlap
	assign list_end_o = (ofs == cell_map_pkg::OFS_NAME_END)
		|| (ofs == cell_map_pkg::OFS_A_LIST_END);

	// A full bucket must be caught before the slot would wrap
	a_slot_no_wrap: assert property (@(posedge clk) disable iff (rst)
		cmd_i == store_ctl_pkg::CUR_NEXT_SLOT |-> !last_slot_o);

endmodule

// File: source/wb_master.sv
`timescale 1ns/1ps

module wb_master (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_i,
	input  logic                    we_i,
	input  store_ctl_pkg::wb_addr_t addr_i,
	input  cell_map_pkg::word_t     data_i,
	output store_ctl_pkg::wb_addr_t wb_addr_o,
	output cell_map_pkg::word_t     wb_data_o,
	output logic                    wb_we_o,
	output logic                    wb_stb_o,
	output logic                    wb_cyc_o,
	input  logic                    wb_ack_i,
	input  cell_map_pkg::word_t     wb_data_i,
	output logic                    ack_o,
	output cell_map_pkg::word_t     rd_data_o
);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			wb_we_o <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			if (req_i) begin
				wb_cyc_o <= 1'b1;
				wb_stb_o <= 1'b1;
				wb_we_o <= we_i;
			end else if (wb_stb_o && wb_ack_i) begin
				wb_cyc_o <= 1'b0;
				wb_stb_o <= 1'b0;
				wb_we_o <= 1'b0;
				ack_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_i) begin
			wb_addr_o <= addr_i;
			wb_data_o <= data_i;
		end
		// Read data is held until the next read completes
		if (wb_stb_o && wb_ack_i && !wb_we_o)
			rd_data_o <= wb_data_i;
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
		wb_stb_o |-> wb_cyc_o);

	a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_addr_o)
			&& $stable(wb_data_o) && $stable(wb_we_o));

	// The controller never stacks a request on an open cycle
	a_one_request: assert property (@(posedge clk) disable iff (rst)
		req_i |-> !wb_cyc_o);

endmodule

// File: source/storage_fsm.sv
`timescale 1ns/1ps

module storage_fsm (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       parser_valid_i,
	output logic                       parser_ready_o,
	input  logic                       hash_done_i,
	input  logic                       ack_i,
	input  cell_map_pkg::word_t        rd_data_i,
	input  cell_map_pkg::word_t        name_word_i,
	input  cell_map_pkg::word_t        addr_word_i,
	input  cell_map_pkg::a_count_t     a_count_i,
	input  logic                       last_slot_i,
	input  logic                       last_addr_i,
	input  logic                       list_end_i,
	output logic                       hash_start_o,
	output logic                       latch_en_o,
	output store_ctl_pkg::cursor_cmd_t cursor_cmd_o,
	output cell_map_pkg::offset_t      load_ofs_o,
	output logic                       req_o,
	output logic                       we_o,
	output cell_map_pkg::word_t        wr_data_o,
	output logic                       stored_o,
	output logic                       overflow_o
);

	typedef enum logic [3:0] {
		S_IDLE, S_HASH_START, S_HASH_WAIT, S_RD_FLAG,
		S_CMP_NAME, S_WR_NAME, S_WR_FLAG, S_RD_QCNT,
		S_WR_QCNT, S_RD_ACNT, S_MERGE, S_SCAN,
		S_WR_ADDR, S_NEXT_ADDR, S_WR_ACNT, S_DONE
	} state_t;

	state_t state, state_next;
	logic wait_q;
	logic claimed_q;
	logic set_ovf;
	logic bus_state;
	cell_map_pkg::word_t a_cnt_q;

	assign parser_ready_o = state == S_IDLE;
	assign latch_en_o = parser_valid_i && parser_ready_o;
	assign hash_start_o = state == S_HASH_START;
	assign stored_o = state == S_DONE;

	assign we_o = state inside {S_WR_NAME, S_WR_FLAG, S_WR_QCNT, S_WR_ADDR, S_WR_ACNT};
	assign bus_state = we_o || state inside {S_RD_FLAG, S_CMP_NAME, S_RD_QCNT,
		S_RD_ACNT, S_SCAN};
	// One request on entry, then wait for the ack
	assign req_o = bus_state && !wait_q;

	always_comb begin
		case (state)
			S_WR_NAME: wr_data_o = name_word_i;
			S_WR_FLAG: wr_data_o = 32'd1;
			S_WR_QCNT: wr_data_o = claimed_q ? 32'd1 : rd_data_i + 32'd1;
			S_WR_ADDR: wr_data_o = addr_word_i;
			default:   wr_data_o = a_cnt_q;
		endcase
	end

	always_comb begin
		state_next = state;
		cursor_cmd_o = store_ctl_pkg::CUR_HOLD;
		load_ofs_o = cell_map_pkg::OFS_IN_USE;
		set_ovf = 1'b0;
		case (state)
			S_IDLE: if (parser_valid_i) state_next = S_HASH_START;
			S_HASH_START: begin
				cursor_cmd_o = store_ctl_pkg::CUR_RESET_SLOT;
				state_next = S_HASH_WAIT;
			end
			S_HASH_WAIT: if (hash_done_i) state_next = S_RD_FLAG;
			S_RD_FLAG: if (ack_i) begin
				cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
				load_ofs_o = cell_map_pkg::OFS_NAME;
				state_next = rd_data_i[0] ? S_CMP_NAME : S_WR_NAME;
			end
			S_CMP_NAME: if (ack_i) begin
				if (rd_data_i != name_word_i) begin
					if (last_slot_i) begin
						set_ovf = 1'b1;
						state_next = S_DONE;
					end else begin
						cursor_cmd_o = store_ctl_pkg::CUR_NEXT_SLOT;
						state_next = S_RD_FLAG;
					end
				end else if (list_end_i) begin
					cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
					load_ofs_o = cell_map_pkg::OFS_QUERY_COUNT;
					state_next = S_RD_QCNT;
				end else begin
					cursor_cmd_o = store_ctl_pkg::CUR_STEP_OFS;
				end
			end
			S_WR_NAME: if (ack_i) begin
				if (list_end_i) begin
					cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
					state_next = S_WR_FLAG;
				end else begin
					cursor_cmd_o = store_ctl_pkg::CUR_STEP_OFS;
				end
			end
			S_WR_FLAG: if (ack_i) begin
				cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
				load_ofs_o = cell_map_pkg::OFS_QUERY_COUNT;
				state_next = S_WR_QCNT;
			end
			S_RD_QCNT: if (ack_i) state_next = S_WR_QCNT;
			S_WR_QCNT: if (ack_i) begin
				if (claimed_q) begin
					state_next = S_MERGE;
				end else begin
					cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
					load_ofs_o = cell_map_pkg::OFS_A_COUNT;
					state_next = S_RD_ACNT;
				end
			end
			S_RD_ACNT: if (ack_i) state_next = S_MERGE;
			S_MERGE: begin
				cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
				if (a_count_i == '0) begin
					load_ofs_o = cell_map_pkg::OFS_A_COUNT;
					state_next = S_WR_ACNT;
				end else begin
					load_ofs_o = cell_map_pkg::OFS_A_LIST;
					state_next = S_SCAN;
				end
			end
			S_SCAN: if (ack_i) begin
				if (rd_data_i == addr_word_i) begin
					state_next = S_NEXT_ADDR;
				end else if (rd_data_i == '0) begin
					state_next = S_WR_ADDR;
				end else if (list_end_i) begin
					// No free entry for this address
					set_ovf = 1'b1;
					state_next = S_NEXT_ADDR;
				end else begin
					cursor_cmd_o = store_ctl_pkg::CUR_STEP_OFS;
				end
			end
			S_WR_ADDR: if (ack_i) state_next = S_NEXT_ADDR;
			S_NEXT_ADDR: begin
				if (last_addr_i) begin
					cursor_cmd_o = store_ctl_pkg::CUR_LOAD_OFS;
					load_ofs_o = cell_map_pkg::OFS_A_COUNT;
					state_next = S_WR_ACNT;
				end else begin
					cursor_cmd_o = store_ctl_pkg::CUR_NEXT_ADDR;
					load_ofs_o = cell_map_pkg::OFS_A_LIST;
					state_next = S_SCAN;
				end
			end
			S_WR_ACNT: if (ack_i) state_next = S_DONE;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			wait_q <= 1'b0;
			claimed_q <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			state <= state_next;
			if (req_o)
				wait_q <= 1'b1;
			else if (ack_i)
				wait_q <= 1'b0;
			if (state == S_HASH_START)
				claimed_q <= 1'b0;
			else if (state == S_RD_FLAG && ack_i && !rd_data_i[0])
				claimed_q <= 1'b1;
			if (set_ovf)
				overflow_o <= 1'b1;
		end
	end

	// Running A counter of the cell
	always_ff @(posedge clk) begin
		if (state == S_WR_QCNT && ack_i && claimed_q)
			a_cnt_q <= '0;
		else if (state == S_RD_ACNT && ack_i)
			a_cnt_q <= rd_data_i;
		else if (state == S_WR_ADDR && ack_i)
			a_cnt_q <= a_cnt_q + 1'b1;
	end

	a_stored_single: assert property (@(posedge clk) disable iff (rst)
		stored_o |=> !stored_o && parser_ready_o);

endmodule

// File: source/storage_top.sv
`timescale 1ns/1ps

module storage_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     parser_valid_i,
	input  cell_map_pkg::name_t      qry_name_i,
	input  cell_map_pkg::addr_list_t ans_addr_i,
	input  cell_map_pkg::a_count_t   ans_a_count_i,
	output logic                     parser_ready_o,
	output store_ctl_pkg::wb_addr_t  wb_addr_o,
	output cell_map_pkg::word_t      wb_data_o,
	input  cell_map_pkg::word_t      wb_data_i,
	output logic                     wb_we_o,
	output logic                     wb_stb_o,
	output logic                     wb_cyc_o,
	input  logic                     wb_ack_i,
	output logic                     stored_o,
	output logic                     overflow_o
);

	logic hash_start, hash_done, latch_en;
	logic req, we, ack_pulse;
	logic last_slot, last_addr, list_end;
	cell_map_pkg::bucket_t bucket;
	cell_map_pkg::name_t name;
	cell_map_pkg::word_t name_word, addr_word, rd_data, wr_data;
	cell_map_pkg::a_count_t a_count;
	cell_map_pkg::offset_t load_ofs;
	logic [cell_map_pkg::WORD_IDX_W-1:0] word_idx;
	logic [cell_map_pkg::ADDR_IDX_W-1:0] addr_idx;
	store_ctl_pkg::cursor_cmd_t cursor_cmd;
	store_ctl_pkg::wb_addr_t cell_addr;

	storage_fsm u_fsm (
		.clk, .rst, .parser_valid_i, .parser_ready_o,
		.hash_done_i(hash_done), .ack_i(ack_pulse), .rd_data_i(rd_data),
		.name_word_i(name_word), .addr_word_i(addr_word), .a_count_i(a_count),
		.last_slot_i(last_slot), .last_addr_i(last_addr), .list_end_i(list_end),
		.hash_start_o(hash_start), .latch_en_o(latch_en),
		.cursor_cmd_o(cursor_cmd), .load_ofs_o(load_ofs),
		.req_o(req), .we_o(we), .wr_data_o(wr_data),
		.stored_o, .overflow_o
	);

	name_hash u_hash (
		.clk, .rst, .start_i(hash_start), .name_i(name),
		.done_o(hash_done), .bucket_o(bucket)
	);

	record_latch u_latch (
		.clk, .latch_en_i(latch_en),
		.qry_name_i, .ans_addr_i, .ans_a_count_i,
		.word_idx_i(word_idx), .addr_idx_i(addr_idx),
		.name_o(name), .name_word_o(name_word), .addr_word_o(addr_word),
		.a_count_o(a_count)
	);

	cell_cursor u_cursor (
		.clk, .rst, .cmd_i(cursor_cmd), .load_ofs_i(load_ofs),
		.bucket_i(bucket), .a_count_i(a_count), .wb_addr_o(cell_addr),
		.word_idx_o(word_idx), .addr_idx_o(addr_idx),
		.last_slot_o(last_slot), .last_addr_o(last_addr), .list_end_o(list_end)
	);

	wb_master u_wb (
		.clk, .rst, .req_i(req), .we_i(we), .addr_i(cell_addr), .data_i(wr_data),
		.wb_addr_o, .wb_data_o, .wb_we_o, .wb_stb_o, .wb_cyc_o,
		.wb_ack_i, .wb_data_i, .ack_o(ack_pulse), .rd_data_o(rd_data)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: bench/wb_memory.sv
`timescale 1ns/1ps

module wb_memory (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  store_ctl_pkg::wb_addr_t wb_addr_i,
	input  cell_map_pkg::word_t     wb_data_i,
	output cell_map_pkg::word_t     wb_data_o,
	output logic                    wb_ack_o
);

	localparam int DEPTH = 1 << store_ctl_pkg::WB_ADDR_W;

	cell_map_pkg::word_t mem [DEPTH];
	logic pending;
	int unsigned delay;

	always @(posedge clk) begin
		if (rst) begin
			// Empty cells read as zero
			for (int i = 0; i < DEPTH; i++)
				mem[i] = '0;
			pending <= 1'b0;
			delay <= 0;
			wb_ack_o <= 1'b0;
			wb_data_o <= '0;
		end else if (wb_ack_o) begin
			wb_ack_o <= 1'b0;
		end else if (pending) begin
			if (delay == 0) begin
				pending <= 1'b0;
				wb_ack_o <= 1'b1;
				if (wb_we_i)
					mem[wb_addr_i] = wb_data_i;
				else
					wb_data_o <= mem[wb_addr_i];
			end else begin
				delay <= delay - 1;
			end
		end else if (wb_cyc_i && wb_stb_i) begin
			// 1 to 3 cycles until the acknowledge
			pending <= 1'b1;
			delay <= $urandom_range(2, 0);
		end
	end

endmodule

// File: bench/storage_tb.sv
`timescale 1ns/1ps

module storage_tb;

	localparam int TIMEOUT = 1000;
	localparam int CELL_WORDS = 1 << cell_map_pkg::OFFSET_BITS;
	localparam int SLOTS = 1 << cell_map_pkg::SLOT_BITS;

	logic clk;
	logic rst;
	logic parser_valid;
	cell_map_pkg::name_t qry_name;
	cell_map_pkg::addr_list_t ans_addr;
	cell_map_pkg::a_count_t ans_a_count;
	logic parser_ready;
	store_ctl_pkg::wb_addr_t wb_addr;
	cell_map_pkg::word_t wb_wdata;
	cell_map_pkg::word_t wb_rdata;
	logic wb_we;
	logic wb_stb;
	logic wb_cyc;
	logic wb_ack;
	logic stored;
	logic overflow;

	int checks = 0;
	int errors = 0;
	int bus_checks = 0;
	int bus_errors = 0;
	bit timed_out = 1'b0;

	logic hold_q = 1'b0;
	logic in_flight = 1'b0;
	store_ctl_pkg::wb_addr_t addr_q;
	cell_map_pkg::word_t data_q;
	logic we_q;

	tb_clock u_clock (.clk, .rst);

	wb_memory u_mem (
		.clk, .rst, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_addr_i(wb_addr), .wb_data_i(wb_wdata), .wb_data_o(wb_rdata), .wb_ack_o(wb_ack)
	);

	storage_top dut (
		.clk, .rst, .parser_valid_i(parser_valid), .qry_name_i(qry_name),
		.ans_addr_i(ans_addr), .ans_a_count_i(ans_a_count), .parser_ready_o(parser_ready),
		.wb_addr_o(wb_addr), .wb_data_o(wb_wdata), .wb_data_i(wb_rdata), .wb_we_o(wb_we),
		.wb_stb_o(wb_stb), .wb_cyc_o(wb_cyc), .wb_ack_i(wb_ack),
		.stored_o(stored), .overflow_o(overflow)
	);

	// Shifts by 16 and 6 minus one copy make a multiply by 65599
	function automatic cell_map_pkg::bucket_t model_bucket(cell_map_pkg::name_t n);
		logic [31:0] h;
		h = '0;
		for (int i = 0; i < cell_map_pkg::NAME_WORDS; i++)
			h = n[i] + h * 32'd65599;
		return h[cell_map_pkg::BUCKET_BITS-1:0];
	endfunction

	function automatic int cell_index(cell_map_pkg::bucket_t b, int slot, int ofs);
		return int'(b) * SLOTS * CELL_WORDS + slot * CELL_WORDS + ofs;
	endfunction

	function automatic cell_map_pkg::name_t random_name();
		cell_map_pkg::name_t n;
		for (int i = 0; i < cell_map_pkg::NAME_WORDS; i++)
			n[i] = $urandom();
		return n;
	endfunction

	function automatic cell_map_pkg::name_t name_in_bucket(cell_map_pkg::bucket_t b);
		cell_map_pkg::name_t n;
		int tries;
		tries = 0;
		do begin
			n = random_name();
			tries++;
		end while (model_bucket(n) != b && tries < 100000);
		return n;
	endfunction

	// Nonzero addresses in 10.0.0.0/8
	function automatic cell_map_pkg::addr_list_t random_addrs();
		cell_map_pkg::addr_list_t a;
		for (int i = 0; i < cell_map_pkg::MAX_A; i++)
			a[i] = {8'd10, 24'($urandom())};
		return a;
	endfunction

	task automatic check_word(string what, cell_map_pkg::word_t got,
		cell_map_pkg::word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t ns %s: got 0x%h, expected 0x%h", $time, what, got, exp);
		end
	endtask

	task automatic check_mem(cell_map_pkg::bucket_t b, int slot, int ofs,
		cell_map_pkg::word_t exp, string label);
		int idx;
		idx = cell_index(b, slot, ofs);
		check_word($sformatf("mem[0x%0h] %s", idx, label), u_mem.mem[idx], exp);
	endtask

	task automatic check_cell(cell_map_pkg::bucket_t b, int slot, cell_map_pkg::name_t n,
		int qcnt, int acnt);
		for (int i = 0; i < cell_map_pkg::NAME_WORDS; i++)
			check_mem(b, slot, int'(cell_map_pkg::OFS_NAME) + i, n[i], "name");
		check_mem(b, slot, int'(cell_map_pkg::OFS_IN_USE), 1, "in-use flag");
		check_mem(b, slot, int'(cell_map_pkg::OFS_QUERY_COUNT), qcnt, "query counter");
		check_mem(b, slot, int'(cell_map_pkg::OFS_A_COUNT), acnt, "A counter");
	endtask

	task automatic check_entry(cell_map_pkg::bucket_t b, int slot, int idx,
		cell_map_pkg::word_t exp);
		check_mem(b, slot, int'(cell_map_pkg::OFS_A_LIST) + idx, exp, "address entry");
	endtask

	task automatic wait_reset_done();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(posedge clk);
			if (!rst)
				return;
		end
		$display("Timeout: reset was not released within %0d cycles", TIMEOUT);
		timed_out = 1'b1;
	endtask

	task automatic wait_ready();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (parser_ready)
				return;
		end
		$display("Timeout: parser_ready_o did not rise within %0d cycles", TIMEOUT);
		timed_out = 1'b1;
	endtask

	task automatic wait_stored();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (stored)
				return;
		end
		$display("Timeout: no stored_o pulse within %0d cycles", TIMEOUT);
		timed_out = 1'b1;
	endtask

	task automatic send_query(cell_map_pkg::name_t n, cell_map_pkg::addr_list_t a,
		cell_map_pkg::a_count_t cnt);
		wait_ready();
		if (timed_out)
			return;
		parser_valid = 1'b1;
		qry_name = n;
		ans_addr = a;
		ans_a_count = cnt;
		@(negedge clk);
		parser_valid = 1'b0;
		wait_stored();
	endtask

	task automatic run_tests();
		cell_map_pkg::name_t name_a;
		cell_map_pkg::addr_list_t addr_a;
		cell_map_pkg::addr_list_t addr_b;
		cell_map_pkg::addr_list_t one;
		cell_map_pkg::bucket_t bkt_a;
		cell_map_pkg::bucket_t bkt_s;
		cell_map_pkg::name_t shared [5];
		cell_map_pkg::word_t snap [SLOTS*CELL_WORDS];
		int base;

		wait_reset_done();
		if (timed_out)
			return;
		@(negedge clk);
		check_word("wb_cyc_o", 32'(wb_cyc), 0);
		check_word("wb_stb_o", 32'(wb_stb), 0);
		check_word("stored_o", 32'(stored), 0);
		check_word("overflow_o", 32'(overflow), 0);
		wait_ready();
		if (timed_out)
			return;

		// New name with three addresses
		name_a = random_name();
		addr_a = random_addrs();
		bkt_a = model_bucket(name_a);
		send_query(name_a, addr_a, 3'd3);
		if (timed_out)
			return;
		check_cell(bkt_a, 0, name_a, 1, 3);
		for (int i = 0; i < 3; i++)
			check_entry(bkt_a, 0, i, addr_a[i]);
		check_entry(bkt_a, 0, 3, 0);

		// Same name, one known address and one new
		addr_b = random_addrs();
		addr_b[0] = addr_a[1];
		send_query(name_a, addr_b, 3'd2);
		if (timed_out)
			return;
		check_cell(bkt_a, 0, name_a, 2, 4);
		for (int i = 0; i < 3; i++)
			check_entry(bkt_a, 0, i, addr_a[i]);
		check_entry(bkt_a, 0, 3, addr_b[1]);
		check_entry(bkt_a, 0, 4, 0);
		check_word("overflow_o", 32'(overflow), 0);

		// Four names in one bucket fill it in arrival order
		bkt_s = bkt_a + 1'b1;
		for (int n = 0; n < 5; n++)
			shared[n] = name_in_bucket(bkt_s);
		for (int n = 0; n < SLOTS; n++) begin
			one = random_addrs();
			send_query(shared[n], one, 3'd1);
			if (timed_out)
				return;
			check_cell(bkt_s, n, shared[n], 1, 1);
			check_entry(bkt_s, n, 0, one[0]);
		end
		check_word("overflow_o", 32'(overflow), 0);

		// A fifth name finds no room
		base = cell_index(bkt_s, 0, 0);
		for (int i = 0; i < SLOTS * CELL_WORDS; i++)
			snap[i] = u_mem.mem[base + i];
		one = random_addrs();
		send_query(shared[4], one, 3'd1);
		if (timed_out)
			return;
		check_word("overflow_o", 32'(overflow), 1);
		for (int i = 0; i < SLOTS * CELL_WORDS; i++)
			check_word($sformatf("mem[0x%0h]", base + i), u_mem.mem[base + i], snap[i]);
	endtask

	task automatic finish_run();
		$display("Checks %0d, errors %0d, bus checks %0d, bus errors %0d",
			checks, errors, bus_checks, bus_errors);
		if (errors == 0 && bus_errors == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	// Bus and handshake rules, sampled on the rising edge
	always @(posedge clk) begin
		if (rst) begin
			in_flight = 1'b0;
		end else begin
			bus_checks++;
			assert (!wb_stb || wb_cyc) else begin
				bus_errors++;
				$display("[FAIL] %0t ns wb_cyc_o: got 0, expected 1 with strobe high", $time);
			end
			if (hold_q) begin
				assert (wb_stb) else begin
					bus_errors++;
					$display("[FAIL] %0t ns wb_stb_o: got 0, expected 1", $time);
				end
				assert (wb_addr == addr_q) else begin
					bus_errors++;
					$display("[FAIL] %0t ns wb_addr_o: got 0x%h, expected 0x%h",
						$time, wb_addr, addr_q);
				end
				assert (wb_wdata == data_q) else begin
					bus_errors++;
					$display("[FAIL] %0t ns wb_data_o: got 0x%h, expected 0x%h",
						$time, wb_wdata, data_q);
				end
				assert (wb_we == we_q) else begin
					bus_errors++;
					$display("[FAIL] %0t ns wb_we_o: got %b, expected %b", $time, wb_we, we_q);
				end
			end
			if (in_flight) begin
				assert (!parser_ready) else begin
					bus_errors++;
					$display("[FAIL] %0t ns parser_ready_o: got 1, expected 0", $time);
				end
				if (stored)
					in_flight = 1'b0;
			end else if (parser_valid && parser_ready) begin
				in_flight = 1'b1;
			end
		end
		hold_q = wb_stb && !wb_ack;
		addr_q = wb_addr;
		data_q = wb_wdata;
		we_q = wb_we;
	end

	initial begin
		parser_valid = 1'b0;
		qry_name = '0;
		ans_addr = '0;
		ans_a_count = '0;
		void'($urandom(11));
		run_tests();
		finish_run();
	end

endmodule

// File: project.f
source/cell_map_pkg.sv
source/store_ctl_pkg.sv
source/name_hash.sv
source/record_latch.sv
source/cell_cursor.sv
source/wb_master.sv
source/storage_fsm.sv
source/storage_top.sv
bench/tb_clock.sv
bench/wb_memory.sv
bench/storage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module storage_tb \
	> build.log 2>&1 \
	&& ./obj_dir/Vstorage_tb > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0
